// ==== flist.f ====
verilog/csr_pkg.sv
verilog/csr_op_decode.sv
verilog/csr_regfile.sv
verilog/trap_ctrl.sv
verilog/commit_stage.sv
verilog/csr_unit_top.sv
verif/csr_checker.sv
verif/csr_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

SIM := obj_dir/Vcsr_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): flist.f verilog/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f flist.f -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/csr_tb.sv ====
// testbench for the CSR unit
// drives one instruction per falling edge, predicts each commit with a software
// model of the machine-mode CSRs and compares it one cycle after the strobe
`default_nettype none

module csr_tb;

    localparam logic [2:0] f3_rw  = 3'd1;
    localparam logic [2:0] f3_rs  = 3'd2;
    localparam logic [2:0] f3_rc  = 3'd3;
    localparam logic [2:0] f3_rsi = 3'd6;
    // reset, then the budget of tests 1 to 6, then a margin
    localparam int run_limit = 16 + 40 + 30 + 20 + 25 + 30 + 50 + 60;

    logic                     clk;
    logic                     wr_mscrstch;
    logic                     instr_valid;
    logic [csr_pkg::xlen-1:0] pc;
    logic [31:0]              instr;
    logic [csr_pkg::xlen-1:0] rs1_value;
    logic                     timer_irq;
    csr_pkg::commit_t         commit;

    // model state, as the DUT holds it after the last rising edge
    logic [63:0] m_mcycle;
    logic [63:0] m_mtvec;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [63:0] m_mscratch;
    logic        m_mie;
    logic        m_mpie;
    logic        m_mtie;
    logic        m_mtip;
    logic [1:0]  m_mpp;
    logic [1:0]  m_fs;

    csr_pkg::commit_t exp_q[$];
    csr_pkg::commit_t exp_c;
    logic [63:0]      rng_state = 64'd21;
    logic [63:0]      last_rd = '0;   // rd_data of the latest checked write-back
    logic             timer_lvl = 1'b0;
    int               errors = 0;
    int               err_mark = 0;
    int               n_steps = 0;
    int               n_tests = 0;
    int               cycles = 0;

    csr_pkg::csr_addr_t all_csrs [10] = '{
        csr_pkg::addr_mcycle, csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mtvec,
        csr_pkg::addr_mscratch, csr_pkg::addr_mepc, csr_pkg::addr_mcause, csr_pkg::addr_mip,
        csr_pkg::addr_mvendorid, 12'h7c0};
    csr_pkg::csr_addr_t rw_csrs [5] = '{
        csr_pkg::addr_mscratch, csr_pkg::addr_mcause, csr_pkg::addr_mie,
        csr_pkg::addr_mtvec, csr_pkg::addr_mepc};

    csr_unit_top dut0 (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .timer_irq   (timer_irq),
        .commit      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] idx,
                                            input logic [4:0] src, input logic [4:0] rd);
        return {idx, src, f3, rd, 7'b1110011};
    endfunction

    function automatic logic [63:0] model_read(input logic [11:0] idx);
        case (idx)
            csr_pkg::addr_mcycle:    return m_mcycle;
            csr_pkg::addr_mstatus:
                return {m_fs == 2'b11, 48'd0, m_fs, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
            csr_pkg::addr_mie:       return {56'd0, m_mtie, 7'd0};
            csr_pkg::addr_mtvec:     return m_mtvec;
            csr_pkg::addr_mscratch:  return m_mscratch;
            csr_pkg::addr_mepc:      return m_mepc;
            csr_pkg::addr_mcause:    return m_mcause;
            csr_pkg::addr_mip:       return {56'd0, m_mtip, 7'd0};
            csr_pkg::addr_mvendorid: return csr_pkg::mvendorid_value;
            default:                 return 64'd0;
        endcase
    endfunction

    // mcycle handled by the caller, mip and mvendorid drop writes
    function automatic void model_write(input logic [11:0] idx, input logic [63:0] v);
        case (idx)
            csr_pkg::addr_mstatus: begin
                m_mie  = v[3];
                m_mpie = v[7];
                m_mpp  = v[12:11];
                m_fs   = v[14:13];
            end
            csr_pkg::addr_mie:      m_mtie = v[7];
            csr_pkg::addr_mtvec:    m_mtvec = {v[63:2], 2'b00};
            csr_pkg::addr_mscratch: m_mscratch = v;
            csr_pkg::addr_mepc:     m_mepc = {v[63:2], 2'b00};
            csr_pkg::addr_mcause:   m_mcause = v;
            default: ;
        endcase
    endfunction

    // expected commit for one cycle; advances the model to the next edge
    function automatic csr_pkg::commit_t predict_commit(input logic v, input logic [31:0] ins,
            input logic [63:0] rs1v, input logic [63:0] pcv, input logic irq);
        csr_pkg::commit_t c;
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [11:0] idx;
        logic [63:0] old;
        logic [63:0] opnd;
        logic [63:0] nv;
        logic        is_csr;
        logic        take_timer;
        logic        do_write;
        c          = '0;
        f3         = ins[14:12];
        src        = ins[19:15];
        idx        = ins[31:20];
        is_csr     = v && (ins[6:0] == 7'h73) && (f3[1:0] != 2'b00);
        take_timer = v && m_mtip && m_mie && m_mtie;
        old        = model_read(idx);
        opnd       = f3[2] ? {59'd0, src} : rs1v;
        case (f3[1:0])
            2'b01:   nv = opnd;
            2'b10:   nv = old | opnd;
            default: nv = old & ~opnd;
        endcase
        do_write = is_csr && !take_timer && (f3[1:0] == 2'b01 || src != 5'd0);
        if (is_csr && !take_timer && ins[11:7] != 5'd0) begin
            c.rd_we   = 1'b1;
            c.rd_idx  = ins[11:7];
            c.rd_data = old;
        end
        if (take_timer || (v && ins == 32'h0000_0073)) begin
            c.redirect = 1'b1;
            c.target   = m_mtvec;
            m_mepc     = {pcv[63:2], 2'b00};
            m_mcause   = take_timer ? 64'h8000_0000_0000_0007 : 64'd11;
            m_mpie     = m_mie;
            m_mie      = 1'b0;
            m_mpp      = 2'b11;
        end else if (v && ins == 32'h3020_0073) begin   // mret
            c.redirect = 1'b1;
            c.target   = m_mepc;
            m_mie      = m_mpie;
            m_mpie     = 1'b1;
            m_mpp      = 2'b00;
        end else if (do_write) begin
            model_write(idx, nv);
        end
        m_mcycle = (do_write && idx == csr_pkg::addr_mcycle) ? nv : m_mcycle + 64'd1;
        m_mtip   = irq;
        return c;
    endfunction

    function automatic string fmt_commit(input csr_pkg::commit_t c);
        return $sformatf("rd_we=%0b rd=%0d data=%h redirect=%0b target=%h",
                         c.rd_we, c.rd_idx, c.rd_data, c.redirect, c.target);
    endfunction

    task automatic check_commit(input csr_pkg::commit_t got, input csr_pkg::commit_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: commit %s, expected %s", $time, fmt_commit(got),
                     fmt_commit(exp));
        end
        if (got.rd_we) begin
            last_rd = got.rd_data;
        end
    endtask

    task automatic check_word(input logic [csr_pkg::xlen-1:0] got,
                              input logic [csr_pkg::xlen-1:0] exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: %s read %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic step(input logic v, input logic [31:0] ins, input logic [63:0] rs1v);
        logic [63:0] pcv;
        pcv = xorshift();
        @(negedge clk);
        wr_mscrstch = 1'b0;
        instr_valid = v;
        instr       = ins;
        rs1_value   = rs1v;
        pc          = pcv;
        timer_irq   = timer_lvl;
        exp_q.push_back(predict_commit(v, ins, rs1v, pcv, timer_lvl));
        n_steps++;
    endtask

    task automatic issue(input logic [31:0] ins, input logic [63:0] rs1v);
        step(1'b1, ins, rs1v);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, 32'd0, 64'd0);
    endtask

    task automatic end_test(input string name);
        idle(2);   // lets the last commit get compared
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
        n_tests++;
    endtask

    // commit of a strobe is visible from the edge after it, checked one edge later
    always @(posedge clk) begin
        cycles++;
        if (exp_q.size() >= 2) begin
            exp_c = exp_q.pop_front();
            check_commit(commit, exp_c);
        end
        if (cycles > run_limit) begin
            $display("timeout: run still going after %0d cycles", run_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        int          sa;
        int          sb;
        wr_mscrstch = 1'b1;
        instr_valid = 1'b0;
        pc          = '0;
        instr       = '0;
        rs1_value   = '0;
        timer_irq   = 1'b0;
        {m_mcycle, m_mtvec, m_mepc, m_mcause, m_mscratch} = '0;
        {m_mie, m_mpie, m_mtie, m_mtip, m_mpp, m_fs} = '0;
        repeat (16) @(posedge clk);

        foreach (all_csrs[i]) issue(enc_csr(f3_rs, all_csrs[i], 5'd0, 5'd1), 64'd0);
        foreach (rw_csrs[i]) begin
            issue(enc_csr(f3_rw, rw_csrs[i], 5'd10, 5'd2), xorshift());
            issue(enc_csr(f3_rs, rw_csrs[i], 5'd0, 5'd3), 64'd0);
        end
        issue(enc_csr(f3_rw, csr_pkg::addr_mip, 5'd10, 5'd2), '1);
        issue(enc_csr(f3_rs, csr_pkg::addr_mip, 5'd0, 5'd3), 64'd0);
        issue(enc_csr(f3_rw, 12'h7c0, 5'd10, 5'd2), xorshift());
        issue(enc_csr(f3_rs, 12'h7c0, 5'd0, 5'd3), 64'd0);
        end_test("1 register round trip");

        issue(enc_csr(f3_rw, csr_pkg::addr_mstatus, 5'd1, 5'd0), 64'h6000);  // fs dirty
        repeat (14) begin
            r = xorshift();
            issue(enc_csr({r[1], 1'b1, r[0]},
                          r[2] ? csr_pkg::addr_mstatus : csr_pkg::addr_mscratch,
                          r[3] ? 5'd0 : r[8:4], 5'd4), xorshift());
        end
        issue(enc_csr(f3_rs, csr_pkg::addr_mstatus, 5'd0, 5'd5), 64'd0);
        end_test("2 set and clear");

        issue(enc_csr(f3_rw, csr_pkg::addr_mtvec, 5'd1, 5'd0), xorshift());
        issue(enc_csr(f3_rsi, csr_pkg::addr_mstatus, 5'd8, 5'd0), 64'd0);
        issue(32'h0000_0073, 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mepc, 5'd0, 5'd5), 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mcause, 5'd0, 5'd6), 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mstatus, 5'd0, 5'd7), 64'd0);
        issue(enc_csr(f3_rw, csr_pkg::addr_mepc, 5'd1, 5'd0), xorshift());
        issue(32'h3020_0073, 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mstatus, 5'd0, 5'd7), 64'd0);
        end_test("3 ecall and mret");

        timer_lvl = 1'b1;
        issue(enc_csr(f3_rc, csr_pkg::addr_mstatus, 5'd1, 5'd0), 64'h8);
        issue(enc_csr(f3_rs, csr_pkg::addr_mie, 5'd1, 5'd0), 64'h80);
        issue(enc_csr(f3_rs, csr_pkg::addr_mscratch, 5'd0, 5'd8), 64'd0);  // mie off
        issue(enc_csr(f3_rsi, csr_pkg::addr_mstatus, 5'd8, 5'd0), 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mscratch, 5'd0, 5'd8), 64'd0);  // trapped
        issue(enc_csr(f3_rs, csr_pkg::addr_mcause, 5'd0, 5'd9), 64'd0);
        issue(enc_csr(f3_rc, csr_pkg::addr_mie, 5'd1, 5'd0), 64'h80);
        issue(enc_csr(f3_rsi, csr_pkg::addr_mstatus, 5'd8, 5'd0), 64'd0);
        issue(enc_csr(f3_rs, csr_pkg::addr_mscratch, 5'd0, 5'd8), 64'd0);  // mtie off
        timer_lvl = 1'b0;
        issue(enc_csr(f3_rs, csr_pkg::addr_mie, 5'd1, 5'd0), 64'h80);
        issue(enc_csr(f3_rs, csr_pkg::addr_mscratch, 5'd0, 5'd8), 64'd0);
        end_test("4 timer interrupt");

        issue(enc_csr(f3_rs, csr_pkg::addr_mcycle, 5'd0, 5'd6), 64'd0);
        sa = n_steps;
        idle(2);
        a = last_rd;
        idle(3);
        issue(enc_csr(f3_rs, csr_pkg::addr_mcycle, 5'd0, 5'd6), 64'd0);
        sb = n_steps;
        idle(2);
        b = last_rd;
        check_word(b - a, 64'(sb - sa), "mcycle");
        r = xorshift();
        issue(enc_csr(f3_rw, csr_pkg::addr_mcycle, 5'd1, 5'd0), r);
        sa = n_steps;
        idle(4);
        issue(enc_csr(f3_rs, csr_pkg::addr_mcycle, 5'd0, 5'd6), 64'd0);
        sb = n_steps;
        idle(2);
        check_word(last_rd, r + 64'(sb - sa - 1), "mcycle");
        end_test("5 mcycle");

        repeat (40) begin
            r = xorshift();
            issue(enc_csr({r[3], r[5:4] == 2'b00 ? 2'b01 : r[5:4]}, all_csrs[r[2:0]],
                          r[10:6], r[15:11]), xorshift());
        end
        end_test("6 back-to-back strobes");

        $display("summary: %0d tests, %0d errors, %0d cycles", n_tests, errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/csr_checker.sv ====
// concurrent checks on the commit output of the CSR unit
// bound into csr_unit_top, watches the strobe and the registered commit
`default_nettype none

module csr_checker (
    input wire logic             clk,
    input wire logic             wr_mscrstch,
    input wire logic             instr_valid,
    input wire csr_pkg::commit_t commit
);

    // a cycle without a strobe commits no redirect
    no_idle_redirect: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !instr_valid |=> !commit.redirect)
        else $error("redirect committed for a cycle without a strobe");

    no_x0_write: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(commit.rd_we && (commit.rd_idx == 5'd0)))
        else $error("rd write-back aimed at x0");

endmodule

bind csr_unit_top csr_checker u_checker (
    .clk         (clk),
    .wr_mscrstch (wr_mscrstch),
    .instr_valid (instr_valid),
    .commit      (commit)
);

`default_nettype wire

// ==== verilog/csr_unit_top.sv ====
// top of the machine-mode CSR unit
// decode and trap logic act in the strobe cycle; CSR state and the commit
// record both update on the following edge
`default_nettype none

module csr_unit_top (
    input  wire logic                     clk,
    input  wire logic                     wr_mscrstch,
    input  wire logic                     instr_valid,
    input  wire logic [csr_pkg::xlen-1:0] pc,
    input  wire logic [31:0]              instr,
    input  wire logic [csr_pkg::xlen-1:0] rs1_value,
    input  wire logic                     timer_irq,
    output csr_pkg::commit_t              commit
);

    csr_pkg::csr_req_t        req;
    csr_pkg::sys_evt_t        evt;
    csr_pkg::trap_t           trap;
    logic [csr_pkg::xlen-1:0] rd_data;
    logic [csr_pkg::xlen-1:0] mtvec;
    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] target;
    logic                     mstatus_mie;
    logic                     mie_mtie;
    logic                     mip_mtip;
    logic                     kill;

    csr_op_decode u_decode (
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .req         (req),
        .evt         (evt)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .req         (req),
        .trap        (trap),
        .pc          (evt.pc),
        .timer_irq   (timer_irq),
        .rd_data     (rd_data),
        .mstatus_mie (mstatus_mie),
        .mie_mtie    (mie_mtie),
        .mip_mtip    (mip_mtip),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    trap_ctrl u_trap (
        .instr_valid (instr_valid),
        .evt         (evt),
        .mstatus_mie (mstatus_mie),
        .mie_mtie    (mie_mtie),
        .mip_mtip    (mip_mtip),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .trap        (trap),
        .target      (target),
        .kill        (kill)
    );

    commit_stage u_commit (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .req         (req),
        .kill        (kill),
        .rd_data     (rd_data),
        .trap        (trap),
        .target      (target),
        .commit      (commit)
    );

endmodule

`default_nettype wire

// ==== verilog/commit_stage.sv ====
// commit register of the CSR unit
// captures the rd write-back and pc redirect one cycle after the strobe;
// a cycle without a strobe leaves an all-zero record
`default_nettype none

module commit_stage (
    input  wire logic                     clk,
    input  wire logic                     wr_mscrstch,
    input  wire csr_pkg::csr_req_t        req,
    input  wire logic                     kill,
    input  wire logic [csr_pkg::xlen-1:0] rd_data,
    input  wire csr_pkg::trap_t           trap,
    input  wire logic [csr_pkg::xlen-1:0] target,
    output csr_pkg::commit_t              commit
);

    csr_pkg::commit_t commit_nxt;
    logic             rd_we;

    // x0 destinations and killed instructions write nothing
    assign rd_we = req.csr_valid && !kill && (req.rd_idx != 5'd0);

    always_comb begin
        commit_nxt = '0;
        if (rd_we) begin
            commit_nxt.rd_we   = 1'b1;
            commit_nxt.rd_idx  = req.rd_idx;
            commit_nxt.rd_data = rd_data;
        end
        commit_nxt.redirect = trap.enter || trap.ret;
        commit_nxt.target   = target;   // already zero without a redirect
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            commit <= '0;
        end else begin
            commit <= commit_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trap_ctrl.sv ====
// trap decision for the CSR unit
// a pending, enabled timer interrupt takes over the strobed instruction,
// otherwise ecall enters the trap and mret returns. combinational
`default_nettype none

module trap_ctrl (
    input  wire logic                     instr_valid,
    input  wire csr_pkg::sys_evt_t        evt,
    input  wire logic                     mstatus_mie,
    input  wire logic                     mie_mtie,
    input  wire logic                     mip_mtip,
    input  wire logic [csr_pkg::xlen-1:0] mtvec,
    input  wire logic [csr_pkg::xlen-1:0] mepc,
    output csr_pkg::trap_t                trap,
    output logic [csr_pkg::xlen-1:0]      target,
    output logic                          kill
);

    logic timer_take;
    logic ecall_take;
    logic mret_take;

    assign timer_take = instr_valid && mip_mtip && mstatus_mie && mie_mtie;
    assign ecall_take = evt.is_ecall && !timer_take;
    assign mret_take  = evt.is_mret && !timer_take;

    assign kill = timer_take;  // instruction in this slot is dropped

    always_comb begin
        trap       = '0;
        trap.enter = timer_take || ecall_take;
        trap.ret   = mret_take;
        if (timer_take) begin
            trap.cause = csr_pkg::cause_m_timer;
        end else if (ecall_take) begin
            trap.cause = csr_pkg::cause_ecall_m;
        end
    end

    always_comb begin
        if (trap.enter) begin
            target = mtvec;
        end else if (trap.ret) begin
            target = mepc;
        end else begin
            target = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
// machine-mode CSR storage
// old value is read combinationally by index; the read-modify-write result
// and any trap entry or mret update land on the next clock edge.
// trap entry and mret win over a software write to the same fields
`default_nettype none

module csr_regfile (
    input  wire logic                     clk,
    input  wire logic                     wr_mscrstch,
    input  wire csr_pkg::csr_req_t        req,
    input  wire csr_pkg::trap_t           trap,
    input  wire logic [csr_pkg::xlen-1:0] pc,
    input  wire logic                     timer_irq,
    output logic [csr_pkg::xlen-1:0]      rd_data,
    output logic                          mstatus_mie,
    output logic                          mie_mtie,
    output logic                          mip_mtip,
    output logic [csr_pkg::xlen-1:0]      mtvec,
    output logic [csr_pkg::xlen-1:0]      mepc
);

    logic [csr_pkg::xlen-1:0] mcycle;
    logic [csr_pkg::xlen-1:0] mcause;
    logic [csr_pkg::xlen-1:0] mscratch;
    logic                     mst_mpie;
    logic [1:0]               mst_mpp;
    logic [1:0]               mst_fs;

    csr_pkg::mstatus_u        mstatus_cur;
    csr_pkg::mstatus_u        mstatus_wr;
    logic [csr_pkg::xlen-1:0] mie_word;
    logic [csr_pkg::xlen-1:0] mip_word;
    logic [csr_pkg::xlen-1:0] old_value;
    logic [csr_pkg::xlen-1:0] wdata;
    logic                     wr_hit;

    // readable views of the sparse registers
    always_comb begin
        mstatus_cur.raw    = '0;
        mstatus_cur.f.mie  = mstatus_mie;
        mstatus_cur.f.mpie = mst_mpie;
        mstatus_cur.f.mpp  = mst_mpp;
        mstatus_cur.f.fs   = mst_fs;
        mstatus_cur.f.sd   = (mst_fs == 2'b11);  // xs is always off
    end

    assign mie_word = {{(csr_pkg::xlen-8){1'b0}}, mie_mtie, 7'd0};
    assign mip_word = {{(csr_pkg::xlen-8){1'b0}}, mip_mtip, 7'd0};

    always_comb begin
        case (req.idx)
            csr_pkg::addr_mcycle:    old_value = mcycle;
            csr_pkg::addr_mstatus:   old_value = mstatus_cur.raw;
            csr_pkg::addr_mie:       old_value = mie_word;
            csr_pkg::addr_mtvec:     old_value = mtvec;
            csr_pkg::addr_mscratch:  old_value = mscratch;
            csr_pkg::addr_mepc:      old_value = mepc;
            csr_pkg::addr_mcause:    old_value = mcause;
            csr_pkg::addr_mip:       old_value = mip_word;
            csr_pkg::addr_mvendorid: old_value = csr_pkg::mvendorid_value;
            default:                 old_value = '0;
        endcase
    end

    assign rd_data = old_value;

    always_comb begin
        case (req.op)
            csr_pkg::op_set:   wdata = old_value | req.operand;
            csr_pkg::op_clear: wdata = old_value & ~req.operand;
            default:           wdata = req.operand;
        endcase
    end

    always_comb begin
        mstatus_wr.raw = wdata;
    end

    // a taken trap drops the instruction's own write
    assign wr_hit = req.csr_valid && req.wr_en && !trap.enter;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle <= '0;
        end else if (wr_hit && (req.idx == csr_pkg::addr_mcycle)) begin
            mcycle <= wdata;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mie <= 1'b0;
            mst_mpie    <= 1'b0;
            mst_mpp     <= 2'b00;
            mst_fs      <= 2'b00;
        end else if (trap.enter) begin
            mst_mpie    <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mst_mpp     <= 2'b11;
        end else if (trap.ret) begin
            mstatus_mie <= mst_mpie;
            mst_mpie    <= 1'b1;
            mst_mpp     <= 2'b00;
        end else if (wr_hit && (req.idx == csr_pkg::addr_mstatus)) begin
            mstatus_mie <= mstatus_wr.f.mie;
            mst_mpie    <= mstatus_wr.f.mpie;
            mst_mpp     <= mstatus_wr.f.mpp;
            mst_fs      <= mstatus_wr.f.fs;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trap.enter) begin
            mepc   <= {pc[csr_pkg::xlen-1:2], 2'b00};
            mcause <= trap.cause;
        end else if (wr_hit) begin
            if (req.idx == csr_pkg::addr_mepc) begin
                mepc <= {wdata[csr_pkg::xlen-1:2], 2'b00};
            end
            if (req.idx == csr_pkg::addr_mcause) begin
                mcause <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtvec    <= '0;
            mscratch <= '0;
            mie_mtie <= 1'b0;
        end else if (wr_hit) begin
            if (req.idx == csr_pkg::addr_mtvec) begin
                mtvec <= {wdata[csr_pkg::xlen-1:2], 2'b00};  // direct mode only
            end
            if (req.idx == csr_pkg::addr_mscratch) begin
                mscratch <= wdata;
            end
            if (req.idx == csr_pkg::addr_mie) begin
                mie_mtie <= wdata[7];
            end
        end
    end

    // pending bit just follows the timer line, software writes ignored
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mip_mtip <= 1'b0;
        end else begin
            mip_mtip <= timer_irq;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_op_decode.sv ====
// instruction decode for the CSR unit
// turns one strobed instruction into a CSR request or an ecall/mret event,
// purely combinational so the request is ready in the strobe cycle
`default_nettype none

module csr_op_decode (
    input  wire logic [0:0]               instr_valid,
    input  wire logic [csr_pkg::xlen-1:0] pc,
    input  wire logic [31:0]              instr,
    input  wire logic [csr_pkg::xlen-1:0] rs1_value,
    output csr_pkg::csr_req_t             req,
    output csr_pkg::sys_evt_t             evt
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1_field;
    logic             is_system;
    logic             is_csr;
    logic             use_imm;
    csr_pkg::csr_op_e op;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];
    assign use_imm   = funct3[2];     // csrrwi/csrrsi/csrrci

    assign is_system = instr_valid[0] && (opcode == csr_pkg::opcode_system);

    // funct3 x00 is the privileged / reserved space
    assign is_csr = is_system && (funct3[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b10:   op = csr_pkg::op_set;
            2'b11:   op = csr_pkg::op_clear;
            default: op = csr_pkg::op_write;
        endcase
    end

    always_comb begin
        req = '0;
        if (is_csr) begin
            req.csr_valid = 1'b1;
            req.idx       = instr[31:20];
            req.op        = op;
            if (use_imm) begin
                req.operand = {{(csr_pkg::xlen-5){1'b0}}, rs1_field};
            end else begin
                req.operand = rs1_value;
            end
            // set/clear from x0 or a zero uimm is a pure read
            req.wr_en  = (op == csr_pkg::op_write) || (rs1_field != 5'd0);
            req.rd_idx = instr[11:7];
        end
    end

    // exact words only, anything else in the system space is ignored
    always_comb begin
        evt          = '0;
        evt.is_ecall = is_system && (instr == csr_pkg::instr_ecall);
        evt.is_mret  = is_system && (instr == csr_pkg::instr_mret);
        evt.pc       = pc;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
// shared constants and types for the machine-mode CSR unit
// design files reference everything here as csr_pkg::name
`default_nettype none

package csr_pkg;

    localparam int xlen = 64;

    typedef logic [11:0] csr_addr_t;

    // machine-mode CSR indices
    localparam csr_addr_t addr_mcycle    = 12'hb00;
    localparam csr_addr_t addr_mstatus   = 12'h300;
    localparam csr_addr_t addr_mie       = 12'h304;
    localparam csr_addr_t addr_mtvec     = 12'h305;
    localparam csr_addr_t addr_mscratch  = 12'h340;
    localparam csr_addr_t addr_mepc      = 12'h341;
    localparam csr_addr_t addr_mcause    = 12'h342;
    localparam csr_addr_t addr_mip       = 12'h344;
    localparam csr_addr_t addr_mvendorid = 12'hf11;

    localparam logic [xlen-1:0] mvendorid_value = 64'h0000_0000_4359_3231; // ascii "CY21"

    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;
    localparam logic [xlen-1:0] cause_m_timer = 64'h8000_0000_0000_0007; // interrupt, code 7

    // instruction encodings
    localparam logic [6:0]  opcode_system = 7'b1110011;
    localparam logic [31:0] instr_ecall   = 32'h0000_0073;
    localparam logic [31:0] instr_mret    = 32'h3020_0073;

    // values follow funct3[1:0] of the zicsr instructions
    typedef enum logic [1:0] {
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic            csr_valid;
        csr_addr_t       idx;
        csr_op_e         op;
        logic [xlen-1:0] operand;   // rs1 or zero-extended uimm
        logic            wr_en;
        logic [4:0]      rd_idx;
    } csr_req_t;

    typedef struct packed {
        logic            is_ecall;
        logic            is_mret;
        logic [xlen-1:0] pc;
    } sys_evt_t;

    typedef struct packed {
        logic            enter;
        logic            ret;
        logic [xlen-1:0] cause;
    } trap_t;

    typedef struct packed {
        logic            rd_we;
        logic [4:0]      rd_idx;
        logic [xlen-1:0] rd_data;
        logic            redirect;
        logic [xlen-1:0] target;
    } commit_t;

    // mstatus at architectural bit positions
    typedef struct packed {
        logic        sd;          // 63
        logic [47:0] pad_62_15;   // xs and above, all zero here
        logic [1:0]  fs;          // 14:13
        logic [1:0]  mpp;         // 12:11
        logic [2:0]  pad_10_8;
        logic        mpie;        // 7
        logic [2:0]  pad_6_4;
        logic        mie;         // 3
        logic [2:0]  pad_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        mstatus_fields_t f;
    } mstatus_u;

endpackage

`default_nettype wire
